/* Bender.yml */
package:
  name: hub75_fm6126

sources:
  - hub75Pkg.sv
  - fm6126Pkg.sv
  - fm6126Init.sv
  - frameBuffer.sv
  - panelScanDriver.sv
  - hub75Top.sv
  - target: test
    files:
      - hub75Top_checker.sv
      - hub75Tb.sv

/* compile.f */
hub75Pkg.sv
fm6126Pkg.sv
fm6126Init.sv
frameBuffer.sv
panelScanDriver.sv
hub75Top.sv
hub75Top_checker.sv
hub75Tb.sv

/* fm6126Init.sv */
/*
 * Programs registers 12 and 13 of the FM6126A column drivers after reset.
 * Drives its own copy of the panel pins until initDone is set, after which
 * the scan driver stops passing them through.
 */
`timescale 1ns/100ps

module fm6126Init (
    input  logic            clk_in,
    input  logic            reset,
    output hub75Pkg::colType initRgb,
    output logic            initLatch,
    output logic            initClock,
    output logic            initBlank,
    output logic            initDone
);

    import hub75Pkg::*;
    import fm6126Pkg::*;

    // one-hot sequence, one low and one high state per column and register
    typedef enum logic [7:0] {
        ST_START  = 8'b0000_0001,
        ST_LOW12  = 8'b0000_0010,
        ST_HIGH12 = 8'b0000_0100,
        ST_LOW13  = 8'b0000_1000,
        ST_HIGH13 = 8'b0001_0000,
        ST_FLUSH  = 8'b0010_0000,
        ST_SETTLE = 8'b0100_0000,
        ST_DONE   = 8'b1000_0000
    } initStateType;

    initStateType           state;
    colAddrType             column;
    logic [PANEL_WIDTH-1:0] latchWindow;
    logic [1:0]             settleCount;
    logic                   wordBit;

    // every column carries bit (column mod 16), so the word repeats four times
    // across the chain and the last driver ends up holding the full word
    always_comb begin
        if (state == ST_LOW13) begin
            wordBit = REG13_WORD[column[3:0]];
        end else begin
            wordBit = REG12_WORD[column[3:0]];
        end
    end

    // timing from the first edge with reset low: start on edge 1, the two
    // passes on edges 2 to 257, flush on 258, settle until initDone on 262
    always_ff @(posedge clk_in) begin
        if (reset) begin
            state       <= ST_START;
            column      <= '0;
            latchWindow <= '0;
            settleCount <= '0;
            initRgb     <= '0;
            initLatch   <= 1'b0;
            initClock   <= 1'b0;
            initBlank   <= 1'b1;
            initDone    <= 1'b0;
        end else begin
            unique case (state)
                ST_START: begin
                    // ones sit on the trailing REG12_LATCH columns and slide down to bit 0
                    column      <= '0;
                    latchWindow <= ~({PANEL_WIDTH{1'b1}} >> REG12_LATCH);
                    state       <= ST_LOW12;
                end
                ST_LOW12, ST_LOW13: begin
                    // data and latch are set up while the clock is low
                    initRgb   <= {3{wordBit}};
                    initLatch <= latchWindow[0];
                    initClock <= 1'b0;
                    initBlank <= 1'b0;
                    state     <= (state == ST_LOW12) ? ST_HIGH12 : ST_HIGH13;
                end
                ST_HIGH12: begin
                    initClock <= 1'b1;
                    column    <= column + 1'b1;
                    if (&column) begin
                        // the column counter wraps to zero for the second pass
                        latchWindow <= ~({PANEL_WIDTH{1'b1}} >> REG13_LATCH);
                        state       <= ST_LOW13;
                    end else begin
                        latchWindow <= latchWindow >> 1;
                        state       <= ST_LOW12;
                    end
                end
                ST_HIGH13: begin
                    initClock   <= 1'b1;
                    column      <= column + 1'b1;
                    latchWindow <= latchWindow >> 1;
                    state       <= (&column) ? ST_FLUSH : ST_LOW13;
                end
                ST_FLUSH: begin
                    // clock back low and LEDs off before the scan takes over
                    initClock <= 1'b0;
                    initLatch <= 1'b0;
                    initBlank <= 1'b1;
                    initRgb   <= '0;
                    state     <= ST_SETTLE;
                end
                ST_SETTLE: begin
                    // a few idle cycles so the drivers see a clean gap after the last command
                    settleCount <= settleCount + 1'b1;
                    if (&settleCount) begin
                        initDone <= 1'b1;
                        state    <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // terminal, initDone stays set until the next reset
                    state <= ST_DONE;
                end
                default: begin
                    state <= ST_START;
                end
            endcase
        end
    end

endmodule

/* fm6126Pkg.sv */
/*
 * Configuration constants for the FM6126A column drivers.
 * Used by the init block that programs the drivers after reset.
 */
package fm6126Pkg;

    // register 12 word, all outputs enabled with the default current setting
    localparam logic [15:0] REG12_WORD = 16'h7FFF;

    // register 13 word, only the output enable bit set
    localparam logic [15:0] REG13_WORD = 16'h0040;

    // the chip decodes the target register from how many clocks
    // latch is held high at the end of the shifted word
    localparam int unsigned REG12_LATCH = 12;
    localparam int unsigned REG13_LATCH = 13;

endpackage

/* frameBuffer.sv */
/*
 * Pixel store for one full frame, one bit per colour channel.
 * The host writes through the write port, the scan driver reads with one
 * cycle of latency. Content is undefined until written.
 */
`timescale 1ns/100ps

module frameBuffer (
    input  logic                clk_in,
    input  logic                writeValid,
    input  hub75Pkg::rowAddrType writeRow,
    input  hub75Pkg::colAddrType writeCol,
    input  hub75Pkg::colType     writePixel,
    input  hub75Pkg::rowAddrType readRow,
    input  hub75Pkg::colAddrType readCol,
    output hub75Pkg::colType     readPixel
);

    import hub75Pkg::*;

    // row in the upper address bits, so one panel row is a contiguous block
    colType pixelMem [PANEL_HEIGHT * PANEL_WIDTH];

    // the host may write at any time, including while init still runs
    always_ff @(posedge clk_in) begin
        if (writeValid) begin
            pixelMem[{writeRow, writeCol}] <= writePixel;
        end
    end

    // registered read, a read that collides with a write sees the old pixel
    always_ff @(posedge clk_in) begin
        readPixel <= pixelMem[{readRow, readCol}];
    end

endmodule

/* hub75Pkg.sv */
/*
 * Geometry, pixel and scan timing definitions for the 64x32 HUB75 panel.
 * Imported by the frame buffer, the scan driver and the top level.
 */
package hub75Pkg;

    // one row of the panel is one full pass over the column driver chain
    localparam int unsigned PANEL_WIDTH = 64;
    localparam int unsigned PANEL_HEIGHT = 32;

    // the panel lights the upper and the lower half together,
    // so one refresh walks half as many row pairs as there are rows
    localparam int unsigned SCAN_ROWS = PANEL_HEIGHT / 2;

    // cycles a latched row pair stays lit before blank rises again.
    // Must stay below the 4 * PANEL_WIDTH cycles it takes to shift the next pair
    localparam int unsigned DISPLAY_CYCLES = 64;

    // one bit per channel, red in bit 2, green in bit 1, blue in bit 0
    typedef logic [2:0] colType;

    // column index inside one row
    typedef logic [$clog2(PANEL_WIDTH)-1:0] colAddrType;

    // row index inside the whole frame
    typedef logic [$clog2(PANEL_HEIGHT)-1:0] rowAddrType;

    // row pair address as it appears on the panel pins
    typedef logic [$clog2(SCAN_ROWS)-1:0] scanAddrType;

endpackage

/* hub75Tb.sv */
/*
 * Directed testbench for the HUB75 top level. Models the panel's column chain,
 * checks the FM6126A init words, the rows shown after host writes and the display time.
 */
`timescale 1ns/100ps

module hub75Tb;

    import hub75Pkg::*;
    import fm6126Pkg::*;

    logic        clk_in = 1'b0;
    logic        reset;
    logic        writeValid;
    rowAddrType  writeRow;
    colAddrType  writeCol;
    colType      writePixel;
    colType      rgbTop;
    colType      rgbBottom;
    logic        pixClock;
    logic        latch;
    logic        blank;
    scanAddrType rowAddr;
    logic        initDone;

    int          errorCount = 0;
    int          checkCount = 0;
    int          latchCount = 0;
    int          assertFails = 0;
    logic [31:0] rngState = 32'd51;

    // panel model with the chain in shift order, so index 0 is the first column shifted
    colType      modelTop [PANEL_WIDTH];
    colType      modelBottom [PANEL_WIDTH];
    colType      shownTop [SCAN_ROWS][PANEL_WIDTH];
    colType      shownBottom [SCAN_ROWS][PANEL_WIDTH];
    colType      initTop [$];
    colType      initBottom [$];
    logic        initLatchSeen [$];
    logic        prevClock = 1'b0;
    logic        prevLatch = 1'b0;
    scanAddrType expectedRow = '0;

    // what the host last wrote, row by row
    colType      frame [PANEL_HEIGHT][PANEL_WIDTH];

    always #50 clk_in = ~clk_in;

    hub75Top u_hub75Top (.*);

    function automatic logic [31:0] lcgStep(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic checkColour(input colType actual, input colType expected, input string name);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic checkBit(input logic actual, input logic expected, input string name);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b",
                     $time, name, actual, expected);
        end
    endtask

    task automatic checkAddr(input scanAddrType actual, input scanAddrType expected,
                             input string name);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    // the panel samples on the pixel clock rise, seen here one falling clock edge later
    always @(negedge clk_in) begin : panelModel
        int col;
        if (!reset && pixClock && !prevClock) begin
            // during init every rise is a command column, kept for the register checks
            if (!initDone) begin
                initTop.push_back(rgbTop);
                initBottom.push_back(rgbBottom);
                initLatchSeen.push_back(latch);
            end
            for (col = 0; col < PANEL_WIDTH - 1; col++) begin
                modelTop[col] = modelTop[col + 1];
                modelBottom[col] = modelBottom[col + 1];
            end
            modelTop[PANEL_WIDTH - 1] = rgbTop;
            modelBottom[PANEL_WIDTH - 1] = rgbBottom;
        end
        // a standalone latch copies the chain into the output registers of the addressed pair
        if (!reset && initDone && latch && !prevLatch && !pixClock) begin
            checkAddr(rowAddr, expectedRow, "rowAddr");
            expectedRow = expectedRow + 1'b1;
            shownTop[rowAddr] = modelTop;
            shownBottom[rowAddr] = modelBottom;
            latchCount++;
        end
        prevClock = pixClock;
        prevLatch = latch;
    end

    task automatic checkIdlePins();
        checkBit(latch, 1'b0, "latch");
        checkBit(pixClock, 1'b0, "pixClock");
        checkBit(blank, 1'b1, "blank");
        checkBit(initDone, 1'b0, "initDone");
        checkAddr(rowAddr, '0, "rowAddr");
    endtask

    // reset for 8 cycles, then initDone must rise on the 262nd edge
    task automatic resetAndInit();
        repeat (8) begin
            @(negedge clk_in);
            checkIdlePins();
        end
        reset = 1'b0;
        @(negedge clk_in);
        checkIdlePins();
        repeat (260) @(negedge clk_in);
        checkBit(initDone, 1'b0, "initDone one cycle early");
        @(negedge clk_in);
        checkBit(initDone, 1'b1, "initDone");
    endtask

    // one register pass covers 64 columns with bit (column mod 16) of the word on all six lines
    task automatic checkConfigPass(input int pass, input logic [15:0] word, input int latchLen);
        int     col;
        int     idx;
        colType expected;
        if (initTop.size() != 2 * PANEL_WIDTH) begin
            errorCount++;
            $display("init shifted %0d columns instead of %0d", initTop.size(), 2 * PANEL_WIDTH);
            return;
        end
        for (col = 0; col < PANEL_WIDTH; col++) begin
            idx = pass * PANEL_WIDTH + col;
            expected = {3{word[col % 16]}};
            checkColour(initTop[idx], expected,
                        $sformatf("init pass %0d col %0d rgbTop", pass, col));
            checkColour(initBottom[idx], expected,
                        $sformatf("init pass %0d col %0d rgbBottom", pass, col));
            checkBit(initLatchSeen[idx], col >= PANEL_WIDTH - latchLen,
                     $sformatf("init pass %0d col %0d latch", pass, col));
        end
    endtask

    // fills the whole frame from the generator or with one colour
    task automatic writeFrame(input bit useRandom, input colType fill);
        int row;
        int col;
        for (row = 0; row < PANEL_HEIGHT; row++) begin
            for (col = 0; col < PANEL_WIDTH; col++) begin
                @(negedge clk_in);
                if (useRandom) begin
                    rngState = lcgStep(rngState);
                    frame[row][col] = colType'(rngState[18:16]);
                end else begin
                    frame[row][col] = fill;
                end
                writeValid = 1'b1;
                writeRow = rowAddrType'(row);
                writeCol = colAddrType'(col);
                writePixel = frame[row][col];
            end
        end
        @(negedge clk_in);
        writeValid = 1'b0;
    endtask

    // sampled on the rising edge, away from the model updates on the falling edge
    task automatic waitForLatches(input int count);
        int target;
        int cycles;
        target = latchCount + count;
        cycles = 0;
        while (latchCount < target && cycles < count * 400) begin
            @(posedge clk_in);
            cycles++;
        end
        if (latchCount < target) begin
            errorCount++;
            $display("timeout, saw only %0d of %0d row latches",
                     count - (target - latchCount), count);
        end
    endtask

    task automatic checkShownFrame();
        int row;
        int col;
        for (row = 0; row < SCAN_ROWS; row++) begin
            for (col = 0; col < PANEL_WIDTH; col++) begin
                checkColour(shownTop[row][col], frame[row][col],
                            $sformatf("rgbTop row %0d col %0d", row, col));
                checkColour(shownBottom[row][col], frame[row + SCAN_ROWS][col],
                            $sformatf("rgbBottom row %0d col %0d", row + SCAN_ROWS, col));
            end
        end
    endtask

    // two latches flush the pair in flight, the next 16 form a clean refresh
    task automatic uniformFill(input colType fill);
        writeFrame(1'b0, fill);
        waitForLatches(2 + SCAN_ROWS);
        checkShownFrame();
    endtask

    task automatic randomFrame();
        writeFrame(1'b1, '0);
        waitForLatches(2 + SCAN_ROWS);
        checkShownFrame();
    endtask

    // blank stays low for exactly DISPLAY_CYCLES after each scan latch
    task automatic displayPeriod();
        int cycles;
        repeat (3) begin
            cycles = 0;
            @(negedge clk_in);
            while (!(latch && initDone) && cycles < 400) begin
                @(negedge clk_in);
                cycles++;
            end
            if (!(latch && initDone)) begin
                errorCount++;
                $display("timeout waiting for a scan latch pulse");
                return;
            end
            repeat (DISPLAY_CYCLES) begin
                @(negedge clk_in);
                checkBit(blank, 1'b0, "blank during display");
            end
            @(negedge clk_in);
            checkBit(blank, 1'b1, "blank after display");
        end
    endtask

    initial begin
        reset = 1'b1;
        writeValid = 1'b0;
        writeRow = '0;
        writeCol = '0;
        writePixel = '0;
        resetAndInit();
        checkConfigPass(0, REG12_WORD, REG12_LATCH);
        checkConfigPass(1, REG13_WORD, REG13_LATCH);
        uniformFill(3'b101);
        randomFrame();
        displayPeriod();
        assertFails = u_hub75Top.u_hub75TopChecker.failCount;
        $display("checks run: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* hub75Top.sv */
/*
 * Top level of the HUB75 panel controller.
 * Connects the FM6126A init block, the frame buffer and the scan driver
 * between the host write port and the panel pins.
 */
`timescale 1ns/100ps

module hub75Top (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  writeValid,
    input  hub75Pkg::rowAddrType  writeRow,
    input  hub75Pkg::colAddrType  writeCol,
    input  hub75Pkg::colType      writePixel,
    output hub75Pkg::colType      rgbTop,
    output hub75Pkg::colType      rgbBottom,
    output logic                  pixClock,
    output logic                  latch,
    output logic                  blank,
    output hub75Pkg::scanAddrType rowAddr,
    output logic                  initDone
);

    import hub75Pkg::*;

    // init block pins on their way to the scan driver
    colType initRgb;
    logic   initLatch;
    logic   initClock;
    logic   initBlank;

    // scan read port of the frame buffer
    rowAddrType readRow;
    colAddrType readCol;
    colType     readPixel;

    fm6126Init u_fm6126Init (
        .clk_in    (clk_in),
        .reset     (reset),
        .initRgb   (initRgb),
        .initLatch (initLatch),
        .initClock (initClock),
        .initBlank (initBlank),
        .initDone  (initDone)
    );

    frameBuffer u_frameBuffer (
        .clk_in     (clk_in),
        .writeValid (writeValid),
        .writeRow   (writeRow),
        .writeCol   (writeCol),
        .writePixel (writePixel),
        .readRow    (readRow),
        .readCol    (readCol),
        .readPixel  (readPixel)
    );

    panelScanDriver u_panelScanDriver (
        .clk_in    (clk_in),
        .reset     (reset),
        .initRgb   (initRgb),
        .initLatch (initLatch),
        .initClock (initClock),
        .initBlank (initBlank),
        .initDone  (initDone),
        .readRow   (readRow),
        .readCol   (readCol),
        .readPixel (readPixel),
        .rgbTop    (rgbTop),
        .rgbBottom (rgbBottom),
        .pixClock  (pixClock),
        .latch     (latch),
        .blank     (blank),
        .rowAddr   (rowAddr)
    );

endmodule

/* hub75Top_checker.sv */
/*
 * Protocol assertions on the panel pins of the HUB75 top level.
 * Bound into the top level by the bind statement at the end.
 */
`timescale 1ns/100ps

module hub75TopChecker (
    input logic                  clk_in,
    input logic                  reset,
    input logic                  pixClock,
    input logic                  latch,
    input logic                  blank,
    input hub75Pkg::scanAddrType rowAddr,
    input logic                  initDone
);

    // number of assertion failures since the start of the run
    int failCount = 0;

    // during the scan latch is a pulse of its own and never meets a pixel clock edge
    latchApartFromClock: assert property (@(posedge clk_in) disable iff (reset)
        (initDone && latch && !$past(latch)) |-> !pixClock)
        else begin
            failCount++;
            $error("scan latch rose while the pixel clock was high");
        end

    // loading the output registers with the LEDs on would show a torn row
    latchWhileBlank: assert property (@(posedge clk_in) disable iff (reset)
        (initDone && latch) |-> blank)
        else begin
            failCount++;
            $error("scan latch high while blank was low");
        end

    rowChangeWhileBlank: assert property (@(posedge clk_in) disable iff (reset)
        (rowAddr != $past(rowAddr)) |-> (blank && $past(blank)))
        else begin
            failCount++;
            $error("rowAddr changed while the LEDs were on");
        end

    // init runs once per reset
    initDoneSticky: assert property (@(posedge clk_in) disable iff (reset)
        $past(initDone) |-> initDone)
        else begin
            failCount++;
            $error("initDone fell after it was set");
        end

endmodule

bind hub75Top hub75TopChecker u_hub75TopChecker (.*);

/* panelScanDriver.sv */
/*
 * Refreshes the panel one row pair at a time from the frame buffer.
 * Until init finishes it registers the init block's pins onto the panel pins,
 * then loops shift, blank, latch and display forever.
 */
`timescale 1ns/100ps

module panelScanDriver (
    input  logic                 clk_in,
    input  logic                 reset,
    input  hub75Pkg::colType     initRgb,
    input  logic                 initLatch,
    input  logic                 initClock,
    input  logic                 initBlank,
    input  logic                 initDone,
    output hub75Pkg::rowAddrType readRow,
    output hub75Pkg::colAddrType readCol,
    input  hub75Pkg::colType     readPixel,
    output hub75Pkg::colType     rgbTop,
    output hub75Pkg::colType     rgbBottom,
    output logic                 pixClock,
    output logic                 latch,
    output logic                 blank,
    output hub75Pkg::scanAddrType rowAddr
);

    import hub75Pkg::*;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_SHIFT,
        ST_BLANK,
        ST_LATCH,
        ST_RELEASE
    } scanStateType;

    typedef logic [$clog2(DISPLAY_CYCLES)-1:0] dispCountType;

    scanStateType state;
    logic [1:0]   phase;
    colAddrType   column;
    scanAddrType  shiftRow;
    dispCountType displayCount;

    // phase 0 reads the upper half, phase 1 the lower half of the same column.
    // Reads in phases 2 and 3 are issued but never used
    assign readRow = phase[0] ? rowAddrType'(shiftRow) + rowAddrType'(SCAN_ROWS)
                              : rowAddrType'(shiftRow);
    assign readCol = column;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state        <= ST_INIT;
            phase        <= '0;
            column       <= '0;
            shiftRow     <= '0;
            displayCount <= '0;
            rgbTop       <= '0;
            rgbBottom    <= '0;
            pixClock     <= 1'b0;
            latch        <= 1'b0;
            blank        <= 1'b1;
            rowAddr      <= '0;
        end else begin
            unique case (state)
                ST_INIT: begin
                    // the init block owns the pins, one register stage in between
                    rgbTop    <= initRgb;
                    rgbBottom <= initRgb;
                    latch     <= initLatch;
                    pixClock  <= initClock;
                    blank     <= initBlank;
                    if (initDone) begin
                        phase  <= '0;
                        column <= '0;
                        state  <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    // four cycles per column, the clock is high only after phase 3
                    phase    <= phase + 1'b1;
                    pixClock <= (phase == 2'd3);
                    // readPixel always answers the address of the previous phase
                    if (phase == 2'd1) begin
                        rgbTop <= readPixel;
                    end
                    if (phase == 2'd2) begin
                        rgbBottom <= readPixel;
                    end
                    if (phase == 2'd3) begin
                        column <= column + 1'b1;
                        if (column == colAddrType'(PANEL_WIDTH - 1)) begin
                            state <= ST_BLANK;
                        end
                    end
                    // the previous pair stays lit while this one shifts in
                    if (!blank) begin
                        if (displayCount == '0) begin
                            blank <= 1'b1;
                        end else begin
                            displayCount <= displayCount - 1'b1;
                        end
                    end
                end
                ST_BLANK: begin
                    // LEDs off and clock low before the column registers are loaded
                    blank    <= 1'b1;
                    pixClock <= 1'b0;
                    state    <= ST_LATCH;
                end
                ST_LATCH: begin
                    // the new row address shows up together with the latch pulse,
                    // both while blank is still high
                    latch   <= 1'b1;
                    rowAddr <= shiftRow;
                    state   <= ST_RELEASE;
                end
                ST_RELEASE: begin
                    // column and phase have wrapped to zero, so the next pair starts here
                    latch        <= 1'b0;
                    blank        <= 1'b0;
                    displayCount <= dispCountType'(DISPLAY_CYCLES - 1);
                    shiftRow     <= shiftRow + 1'b1;
                    state        <= ST_SHIFT;
                end
                default: begin
                    state <= ST_INIT;
                end
            endcase
        end
    end

endmodule
